// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := index_gen_tb
FILELIST := index_gen.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless the log reports a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: index_gen.f
verilog/index_gen_pkg.sv
verilog/index_gen_if.sv
verilog/index_counter.sv
verilog/request_builder.sv
verilog/request_queue.sv
verilog/index_gen_ctrl.sv
verilog/index_gen_top.sv
test/index_gen_tb.sv

// File: test/index_gen_tb.sv
/* CSR index generator testbench */

`timescale 1ns/1ps

module index_gen_tb import index_gen_pkg::*; ();

    logic               ap_clk;
    logic               areset_generator;
    logic               cfg_valid;
    logic               cfg_ready;
    logic [INDEX_W-1:0] cfg_index_start;
    logic [INDEX_W-1:0] cfg_index_end;
    logic [INDEX_W-1:0] cfg_stride;
    logic [ADDR_W-1:0]  cfg_array_pointer;
    logic               cfg_shift_left;
    logic [SHIFT_W-1:0] cfg_shift_amount;
    logic               req_valid;
    logic [INDEX_W-1:0] req_index;
    logic [ADDR_W-1:0]  req_base;
    logic [ADDR_W-1:0]  req_offset;
    logic               credit_return = 1'b0;
    logic               done;

    // Expected requests, oldest first
    logic [INDEX_W-1:0] exp_index [$];
    logic [ADDR_W-1:0]  exp_base [$];
    logic [ADDR_W-1:0]  exp_offset [$];

    int    received;
    int    returned;
    int    credit_delay;
    int    max_delay;
    bit    withhold;
    int    done_count;
    int    done_before;
    bit    prog_full_seen;
    int    test_errors;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    seed;
    string cur_test;

    index_gen_top uut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // Offset is the index scaled up or down by a power of two
    function automatic logic [ADDR_W-1:0] expected_offset(input logic [INDEX_W-1:0] idx,
                                                         input logic left,
                                                         input logic [SHIFT_W-1:0] amt);
        logic [ADDR_W-1:0] wide;
        logic [ADDR_W-1:0] scale;
        wide  = ADDR_W'(idx);
        scale = 1;
        repeat (amt) scale = scale * 2;
        return left ? (wide * scale) : (wide / scale);
    endfunction

    task automatic report_mismatch(input string field, input logic [ADDR_W-1:0] expected,
                                   input logic [ADDR_W-1:0] actual);
        $display("** Error %s: %s expected 'h%0h, actual 'h%0h", cur_test, field, expected,
                 actual);
        test_errors++;
    endtask

    // ----------------------------------------------------------
    // Output monitor and consumer credit model
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        logic [INDEX_W-1:0] e_index;
        logic [ADDR_W-1:0]  e_base;
        logic [ADDR_W-1:0]  e_offset;
        if (done) begin
            done_count++;
            if (exp_index.size() != 0) begin
                $display("%s: done came while %0d requests were still missing", cur_test,
                         exp_index.size());
                test_errors++;
            end
        end
        if (uut.prog_full) prog_full_seen = 1'b1;
        if (req_valid) begin
            received++;
            if (received - returned > CREDIT_MAX) begin
                $display("%s: more than %0d requests outstanding", cur_test, CREDIT_MAX);
                test_errors++;
            end
            if (exp_index.size() == 0) begin
                $display("%s: unexpected request with index %0d", cur_test, req_index);
                test_errors++;
            end else begin
                e_index  = exp_index.pop_front();
                e_base   = exp_base.pop_front();
                e_offset = exp_offset.pop_front();
                if (req_index != e_index) report_mismatch("index", e_index, req_index);
                if (req_base != e_base) report_mismatch("base", e_base, req_base);
                if (req_offset != e_offset) report_mismatch("offset", e_offset, req_offset);
            end
        end
    end

    // One credit back per request, after a random gap
    always @(posedge ap_clk) begin
        credit_return <= 1'b0;
        if (!withhold && received > returned) begin
            if (credit_delay == 0) begin
                credit_return <= 1'b1;
                returned++;
                credit_delay = $urandom_range(0, max_delay);
            end else begin
                credit_delay--;
            end
        end
    end

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic send_descriptor(input logic [INDEX_W-1:0] start,
                                   input logic [INDEX_W-1:0] stop,
                                   input logic [INDEX_W-1:0] stride,
                                   input logic [ADDR_W-1:0] ptr, input logic left,
                                   input logic [SHIFT_W-1:0] amt);
        logic [INDEX_W-1:0] idx;
        int                 wait_cycles;
        idx = start;
        while (idx < stop) begin
            exp_index.push_back(idx);
            exp_base.push_back(ptr);
            exp_offset.push_back(expected_offset(idx, left, amt));
            idx = idx + stride;
        end
        done_before = done_count;
        wait_cycles = 0;
        @(negedge ap_clk);
        while (!cfg_ready && wait_cycles < 1000) begin
            @(negedge ap_clk);
            wait_cycles++;
        end
        if (!cfg_ready) begin
            $display("%s: cfg_ready never went high", cur_test);
            test_errors++;
        end
        @(posedge ap_clk);
        cfg_valid         <= 1'b1;
        cfg_index_start   <= start;
        cfg_index_end     <= stop;
        cfg_stride        <= stride;
        cfg_array_pointer <= ptr;
        cfg_shift_left    <= left;
        cfg_shift_amount  <= amt;
        @(posedge ap_clk);
        cfg_valid <= 1'b0;
    endtask

    task automatic finish_descriptor();
        int wait_cycles;
        wait_cycles = 0;
        @(negedge ap_clk);
        while (!done && wait_cycles < 20000) begin
            @(negedge ap_clk);
            wait_cycles++;
        end
        if (!done) begin
            $display("%s: timed out waiting for done", cur_test);
            test_errors++;
        end else begin
            @(negedge ap_clk);
            if (!cfg_ready) begin
                $display("%s: cfg_ready did not return high after done", cur_test);
                test_errors++;
            end
            repeat (2) @(negedge ap_clk);
            if (done_count - done_before != 1) begin
                $display("%s: expected one done pulse, saw %0d", cur_test,
                         done_count - done_before);
                test_errors++;
            end
            if (exp_index.size() != 0) begin
                $display("%s: %0d requests never arrived", cur_test, exp_index.size());
                test_errors++;
            end
        end
        exp_index.delete();
        exp_base.delete();
        exp_offset.delete();
    endtask

    // Shift mode 0 is left, 1 is right, 2 picks at random
    task automatic run_random(input int shift_mode);
        logic [INDEX_W-1:0] start;
        logic [INDEX_W-1:0] stride;
        logic [ADDR_W-1:0]  ptr;
        logic               left;
        start  = $urandom_range(0, 2000);
        stride = $urandom_range(1, 5);
        ptr    = ADDR_W'({$urandom(), $urandom()});
        left   = (shift_mode == 2) ? 1'($urandom_range(0, 1)) : (shift_mode == 0);
        send_descriptor(start, start + $urandom_range(1, 100), stride, ptr, left,
                        SHIFT_W'($urandom_range(0, 7)));
        finish_descriptor();
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        seed              = $urandom(32'h5fc9);
        areset_generator  = 1'b1;
        cfg_valid         = 1'b0;
        cfg_index_start   = '0;
        cfg_index_end     = '0;
        cfg_stride        = '0;
        cfg_array_pointer = '0;
        cfg_shift_left    = 1'b0;
        cfg_shift_amount  = '0;
        max_delay         = 3;
        repeat (16) @(posedge ap_clk);
        areset_generator <= 1'b0;

        begin_test("post_reset");
        repeat (10) begin
            @(negedge ap_clk);
            if (!cfg_ready || done || req_valid) begin
                $display("%s: outputs not idle after reset", cur_test);
                test_errors++;
            end
        end
        end_test();

        begin_test("random_descriptors");
        repeat (20) run_random(2);
        end_test();

        begin_test("shift_directions");
        repeat (4) run_random(0);
        repeat (4) run_random(1);
        end_test();

        begin_test("slow_credits");
        max_delay = 40;
        repeat (3) run_random(2);
        max_delay = 3;
        end_test();

        begin_test("empty_range");
        send_descriptor(50, 50, 1, 48'h1000, 1'b1, 3'd2);
        finish_descriptor();
        send_descriptor(90, 20, 2, 48'h2000, 1'b0, 3'd1);
        finish_descriptor();
        end_test();

        // Credits held back long enough for the queue to reach prog_full
        begin_test("queue_backpressure");
        max_delay      = 2;
        withhold       = 1'b1;
        prog_full_seen = 1'b0;
        send_descriptor(0, 100, 1, 48'h0000_dead_0000, 1'b1, 3'd3);
        repeat (40) @(negedge ap_clk);
        if (!prog_full_seen) begin
            $display("%s: prog_full never rose while credits were held back", cur_test);
            test_errors++;
        end
        withhold = 1'b0;
        finish_descriptor();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/index_counter.sv
/* Strided index counter */

`timescale 1ns/1ps

module index_counter import index_gen_pkg::*; (
    input  logic      ap_clk,
    input  logic      areset_generator,
    counter_if.counter cnt
);

    logic [INDEX_W-1:0] count_next;

    // Load wins over a stride step
    always_comb begin
        if (cnt.load) begin
            count_next = cnt.load_value;
        end else if (cnt.enable) begin
            count_next = cnt.count + cnt.stride;
        end else begin
            count_next = cnt.count;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cnt.count <= '0;
        end else begin
            cnt.count <= count_next;
        end
    end

endmodule

// File: verilog/index_gen_ctrl.sv
/* Index generator sequencer */

`timescale 1ns/1ps

module index_gen_ctrl import index_gen_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  logic [INDEX_W-1:0] cfg_index_start,
    input  logic [INDEX_W-1:0] cfg_index_end,
    input  logic [INDEX_W-1:0] cfg_stride,
    input  logic [ADDR_W-1:0]  cfg_array_pointer,
    input  logic               cfg_shift_left,
    input  logic [SHIFT_W-1:0] cfg_shift_amount,
    counter_if.ctrl            cnt,
    output logic               issue,
    output logic [ADDR_W-1:0]  base,
    output logic               shift_left,
    output logic [SHIFT_W-1:0] shift_amount,
    input  logic               prog_full,
    input  logic               empty,
    output logic               done
);

    logic [2:0]         state;
    logic [2:0]         state_next;
    logic [INDEX_W-1:0] index_end;
    logic [INDEX_W-1:0] stride;
    logic               accept;
    logic               below_end;

    assign accept    = cfg_valid & cfg_ready;
    assign below_end = cnt.count < index_end;

    // ----------------------------------------------------------
    // Descriptor registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            index_end    <= cfg_index_end;
            stride       <= cfg_stride;
            base         <= cfg_array_pointer;
            shift_left   <= cfg_shift_left;
            shift_amount <= cfg_shift_amount;
        end
    end

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:  if (accept) state_next = ST_LOAD;
            ST_LOAD:  state_next = ST_RUN;
            ST_RUN: begin
                if (!below_end) begin
                    state_next = ST_DRAIN;
                end else if (prog_full) begin
                    state_next = ST_PAUSE;
                end
            end
            ST_PAUSE: if (!prog_full) state_next = ST_RUN;
            // Last entry is already in the queue here
            ST_DRAIN: if (empty) state_next = ST_DONE;
            ST_DONE:  state_next = ST_IDLE;
            default:  state_next = ST_IDLE;
        endcase
    end

    assign cfg_ready = (state == ST_IDLE);
    assign done      = (state == ST_DONE);

    // Queue filling up stops issue in the same cycle
    assign issue = (state == ST_RUN) & below_end & ~prog_full;

    // Start index is loaded straight from the descriptor port
    assign cnt.load       = accept;
    assign cnt.load_value = cfg_index_start;
    assign cnt.enable     = issue;
    assign cnt.stride     = stride;

    // Each issued index moves the counter on by one stride
    a_issue_steps: assert property (@(posedge ap_clk) disable iff (areset_generator)
        issue |=> cnt.count == $past(cnt.count + stride));

endmodule

// File: verilog/index_gen_if.sv
/* Index generator internal interfaces */

`timescale 1ns/1ps

// Sequencer to index counter
interface counter_if import index_gen_pkg::*; ();

    logic               load;
    logic               enable;
    logic [INDEX_W-1:0] load_value;
    logic [INDEX_W-1:0] stride;
    logic [INDEX_W-1:0] count;

    modport ctrl (
        output load, enable, load_value, stride,
        input  count
    );

    modport counter (
        input  load, enable, load_value, stride,
        output count
    );

endinterface

// Built request into the queue, one push per valid cycle
interface index_req_if import index_gen_pkg::*; ();

    logic               valid;
    logic [INDEX_W-1:0] index;
    logic [ADDR_W-1:0]  base;
    logic [ADDR_W-1:0]  offset;

    modport source (output valid, index, base, offset);

    modport sink (input valid, index, base, offset);

endinterface

// File: verilog/index_gen_pkg.sv
/* Index generator shared constants */

package index_gen_pkg;

    // ----------------------------------------------------------
    // Datapath widths
    // ----------------------------------------------------------
    localparam int INDEX_W = 32;
    localparam int ADDR_W  = 48;
    localparam int SHIFT_W = 3;

    // Request queue sizing, pointers wrap at the depth
    localparam int QUEUE_DEPTH       = 16;
    localparam int QUEUE_PROG_THRESH = 12;
    localparam int QUEUE_PTR_W       = 4;

    // Credits the consumer grants after reset
    localparam int CREDIT_MAX = 8;
    localparam int CREDIT_W   = 4;

    // ----------------------------------------------------------
    // Sequencer FSM encoding
    // ----------------------------------------------------------
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_LOAD  = 3'd1;
    localparam logic [2:0] ST_RUN   = 3'd2;
    localparam logic [2:0] ST_PAUSE = 3'd3;
    localparam logic [2:0] ST_DRAIN = 3'd4;
    localparam logic [2:0] ST_DONE  = 3'd5;

endpackage

// File: verilog/index_gen_top.sv
/* CSR index generator top level */

`timescale 1ns/1ps

module index_gen_top import index_gen_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    // Descriptor
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  logic [INDEX_W-1:0] cfg_index_start,
    input  logic [INDEX_W-1:0] cfg_index_end,
    input  logic [INDEX_W-1:0] cfg_stride,
    input  logic [ADDR_W-1:0]  cfg_array_pointer,
    input  logic               cfg_shift_left,
    input  logic [SHIFT_W-1:0] cfg_shift_amount,
    // Requests to the consumer
    output logic               req_valid,
    output logic [INDEX_W-1:0] req_index,
    output logic [ADDR_W-1:0]  req_base,
    output logic [ADDR_W-1:0]  req_offset,
    input  logic               credit_return,
    output logic               done
);

    logic               issue;
    logic [ADDR_W-1:0]  base;
    logic               shift_left;
    logic [SHIFT_W-1:0] shift_amount;
    logic               prog_full;
    logic               empty;

    counter_if   cnt_if ();
    index_req_if req_if ();

    index_gen_ctrl u_ctrl (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .cfg_index_start   (cfg_index_start),
        .cfg_index_end     (cfg_index_end),
        .cfg_stride        (cfg_stride),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_shift_left    (cfg_shift_left),
        .cfg_shift_amount  (cfg_shift_amount),
        .cnt               (cnt_if.ctrl),
        .issue             (issue),
        .base              (base),
        .shift_left        (shift_left),
        .shift_amount      (shift_amount),
        .prog_full         (prog_full),
        .empty             (empty),
        .done              (done)
    );

    index_counter u_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cnt              (cnt_if.counter)
    );

    request_builder u_builder (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .issue            (issue),
        .count            (cnt_if.count),
        .base             (base),
        .shift_left       (shift_left),
        .shift_amount     (shift_amount),
        .req              (req_if.source)
    );

    request_queue u_queue (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .req              (req_if.sink),
        .credit_return    (credit_return),
        .req_valid        (req_valid),
        .req_index        (req_index),
        .req_base         (req_base),
        .req_offset       (req_offset),
        .prog_full        (prog_full),
        .empty            (empty)
    );

endmodule

// File: verilog/request_builder.sv
/* Request address formation */

`timescale 1ns/1ps

module request_builder import index_gen_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               issue,
    input  logic [INDEX_W-1:0] count,
    input  logic [ADDR_W-1:0]  base,
    input  logic               shift_left,
    input  logic [SHIFT_W-1:0] shift_amount,
    index_req_if.source        req
);

    logic [ADDR_W-1:0] index_wide;
    logic [ADDR_W-1:0] offset_next;

    // Widen first so a left shift keeps the upper bits
    assign index_wide = {{(ADDR_W-INDEX_W){1'b0}}, count};

    always_comb begin
        if (shift_left) begin
            offset_next = index_wide << shift_amount;
        end else begin
            offset_next = index_wide >> shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (issue) begin
            req.index  <= count;
            req.base   <= base;
            req.offset <= offset_next;
        end
    end

endmodule

// File: verilog/request_queue.sv
/* Request FIFO with credit gated output */

`timescale 1ns/1ps

module request_queue import index_gen_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    index_req_if.sink          req,
    input  logic               credit_return,
    output logic               req_valid,
    output logic [INDEX_W-1:0] req_index,
    output logic [ADDR_W-1:0]  req_base,
    output logic [ADDR_W-1:0]  req_offset,
    output logic               prog_full,
    output logic               empty
);

    logic [INDEX_W-1:0]     mem_index  [QUEUE_DEPTH];
    logic [ADDR_W-1:0]      mem_base   [QUEUE_DEPTH];
    logic [ADDR_W-1:0]      mem_offset [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   fill_count;
    logic [CREDIT_W-1:0]    credit_count;
    logic                   full;
    logic                   pop;

    assign empty     = (fill_count == '0);
    assign full      = (fill_count == QUEUE_DEPTH);
    assign prog_full = (fill_count >= QUEUE_PROG_THRESH);

    // A returning credit can be spent in the cycle it arrives
    assign pop = ~empty & ((credit_count != '0) | credit_return);

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (req.valid) begin
            mem_index[wr_ptr]  <= req.index;
            mem_base[wr_ptr]   <= req.base;
            mem_offset[wr_ptr] <= req.offset;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill_count   <= '0;
            credit_count <= CREDIT_W'(CREDIT_MAX);
        end else begin
            if (req.valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({req.valid, pop})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
            case ({credit_return, pop})
                2'b10:   credit_count <= credit_count + 1'b1;
                2'b01:   credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            req_index  <= mem_index[rd_ptr];
            req_base   <= mem_base[rd_ptr];
            req_offset <= mem_offset[rd_ptr];
        end
    end

    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        req.valid |-> !full);

    a_credit_bound: assert property (@(posedge ap_clk) disable iff (areset_generator)
        credit_count <= CREDIT_MAX);

endmodule
